//--- design/ob_cfg_pkg.sv
// order book field widths
// value types shared by store, scan and control

package ob_cfg_pkg;

    // price in ticks
    localparam int PRICE_W = 32;

    // resting share count
    localparam int QTY_W = 16;

    // exchange order reference
    localparam int ID_W = 32;

    typedef logic [PRICE_W-1:0] price_t;

    typedef logic [QTY_W-1:0] qty_t;

    typedef logic [ID_W-1:0] order_id_t;

    // empty side reads as this price
    localparam price_t NO_PRICE = '0;

endpackage

//--- design/ob_msg_pkg.sv
// order book message encodings

package ob_msg_pkg;

    // order type field from the parser
    typedef enum logic [1:0] {
        ADD     = 2'd0,
        CANCEL  = 2'd1,
        EXECUTE = 2'd2
    } order_kind_e;

    // trade type field, 0 is the buy side
    typedef enum logic {
        SIDE_BID = 1'b0,
        SIDE_ASK = 1'b1
    } book_side_e;

    // one-cycle request from control to a side store
    typedef enum logic [1:0] {
        NONE,
        APPEND,
        REMOVE,
        REDUCE
    } store_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        STORE_OP,
        SCAN,
        FINISH
    } ctrl_state_e;

endpackage

//--- design/book_store.sv
`timescale 1ns/1ns
// per-side order memory

module book_store #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    localparam int SW = $clog2(NUM_STOCKS),
    localparam int IW = $clog2(BOOK_DEPTH)
) (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  ob_msg_pkg::store_cmd_e i_cmd,
    input  logic [SW-1:0]          i_stock,
    input  ob_cfg_pkg::qty_t       i_qty,
    input  ob_cfg_pkg::price_t     i_price,
    input  ob_cfg_pkg::order_id_t  i_id,
    output logic                   o_done,
    output logic                   o_found,
    input  logic [SW-1:0]          i_rd_stock,
    input  logic [IW-1:0]          i_rd_idx,
    output ob_cfg_pkg::price_t     o_rd_price,
    output logic                   o_rd_valid
);

    localparam int CW = $clog2(BOOK_DEPTH + 1);
    localparam int AW = $clog2(NUM_STOCKS * BOOK_DEPTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEARCH,
        S_SHIFT
    } store_state_e;

    store_state_e state;

    // compacted entries, stock s owns slots s*BOOK_DEPTH and up
    ob_cfg_pkg::qty_t      qty_mem   [NUM_STOCKS*BOOK_DEPTH];
    ob_cfg_pkg::price_t    price_mem [NUM_STOCKS*BOOK_DEPTH];
    ob_cfg_pkg::order_id_t id_mem    [NUM_STOCKS*BOOK_DEPTH];
    logic [CW-1:0]         count     [NUM_STOCKS];

    logic [CW-1:0] idx;
    logic          r_reduce;

    logic [CW-1:0] cnt;
    logic [AW-1:0] base;
    logic [AW-1:0] cur_addr;
    logic [AW-1:0] app_addr;
    logic [AW-1:0] rd_addr;
    logic          full;
    logic          in_range;
    logic          hit;
    logic          take_all;
    logic          more;

    assign cnt      = count[i_stock];
    assign base     = AW'(i_stock) * AW'(BOOK_DEPTH);
    assign cur_addr = base + AW'(idx);
    assign app_addr = base + AW'(cnt);
    assign full     = (cnt == CW'(BOOK_DEPTH));
    assign in_range = (idx < cnt);
    assign hit      = in_range && (id_mem[cur_addr] == i_id);
    // execute of the whole remainder removes the entry
    assign take_all = !r_reduce || (i_qty >= qty_mem[cur_addr]);
    assign more     = (idx + 1'b1) < cnt;

    // scanner read port
    assign rd_addr    = AW'(i_rd_stock) * AW'(BOOK_DEPTH) + AW'(i_rd_idx);
    assign o_rd_price = price_mem[rd_addr];
    assign o_rd_valid = (CW'(i_rd_idx) < count[i_rd_stock]);

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_cmd == ob_msg_pkg::APPEND && !full) begin
            qty_mem[app_addr]   <= i_qty;
            price_mem[app_addr] <= i_price;
            id_mem[app_addr]    <= i_id;
        end else if (state == S_SEARCH && hit && !take_all) begin
            qty_mem[cur_addr] <= qty_mem[cur_addr] - i_qty;
        end else if (state == S_SHIFT) begin
            if (more) begin
                qty_mem[cur_addr]   <= qty_mem[cur_addr + 1'b1];
                price_mem[cur_addr] <= price_mem[cur_addr + 1'b1];
                id_mem[cur_addr]    <= id_mem[cur_addr + 1'b1];
            end else begin
                // old last slot of the stock
                qty_mem[cur_addr]   <= '0;
                price_mem[cur_addr] <= '0;
                id_mem[cur_addr]    <= '0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state    <= S_IDLE;
            idx      <= '0;
            r_reduce <= 1'b0;
            o_done   <= 1'b0;
            o_found  <= 1'b0;
            for (int s = 0; s < NUM_STOCKS; s++) begin
                count[s] <= '0;
            end
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_cmd == ob_msg_pkg::APPEND) begin
                        if (!full) begin
                            count[i_stock] <= cnt + 1'b1;
                        end
                        o_done  <= 1'b1;
                        o_found <= !full;
                    end else if (i_cmd != ob_msg_pkg::NONE) begin
                        idx      <= '0;
                        r_reduce <= (i_cmd == ob_msg_pkg::REDUCE);
                        state    <= S_SEARCH;
                    end
                end
                S_SEARCH: begin
                    if (!in_range) begin
                        // id not on this side
                        o_done  <= 1'b1;
                        o_found <= 1'b0;
                        state   <= S_IDLE;
                    end else if (hit) begin
                        if (take_all) begin
                            state <= S_SHIFT;
                        end else begin
                            o_done  <= 1'b1;
                            o_found <= 1'b1;
                            state   <= S_IDLE;
                        end
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                S_SHIFT: begin
                    if (more) begin
                        idx <= idx + 1'b1;
                    end else begin
                        count[i_stock] <= cnt - 1'b1;
                        o_done         <= 1'b1;
                        o_found        <= 1'b1;
                        state          <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- design/best_price_scan.sv
`timescale 1ns/1ns
// best price scanner

module best_price_scan #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    parameter bit FIND_MAX   = 1'b1,
    localparam int SW = $clog2(NUM_STOCKS),
    localparam int IW = $clog2(BOOK_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_start,
    input  logic [SW-1:0]      i_stock,
    output logic [SW-1:0]      o_rd_stock,
    output logic [IW-1:0]      o_rd_idx,
    input  ob_cfg_pkg::price_t i_rd_price,
    input  logic               i_rd_valid,
    output logic               o_done,
    output ob_cfg_pkg::price_t o_best
);

    logic busy;
    logic have_any;
    logic better;

    // highest for bids, lowest for asks
    assign better = FIND_MAX ? (i_rd_price > o_best) : (i_rd_price < o_best);

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            busy     <= 1'b0;
            o_done   <= 1'b0;
            o_rd_idx <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                busy     <= 1'b1;
                o_rd_idx <= '0;
            end else if (busy) begin
                o_rd_idx <= o_rd_idx + 1'b1;
                // one slot per cycle, done after the last slot
                if (o_rd_idx == IW'(BOOK_DEPTH - 1)) begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            o_rd_stock <= i_stock;
            o_best     <= ob_cfg_pkg::NO_PRICE;
            have_any   <= 1'b0;
        end else if (busy && i_rd_valid && (!have_any || better)) begin
            o_best   <= i_rd_price;
            have_any <= 1'b1;
        end
    end

endmodule

//--- design/book_ctrl.sv
`timescale 1ns/1ns
// order book sequencer

module book_ctrl #(
    parameter int NUM_STOCKS = 4,
    localparam int SW = $clog2(NUM_STOCKS)
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_data_valid,
    input  logic                    i_trade_type,
    input  logic [SW-1:0]           i_stock_id,
    input  ob_msg_pkg::order_kind_e i_order_type,
    input  ob_cfg_pkg::qty_t        i_quantity,
    input  ob_cfg_pkg::price_t      i_price,
    input  ob_cfg_pkg::order_id_t   i_order_id,
    input  logic                    i_trading_logic_ready,
    output ob_msg_pkg::store_cmd_e  o_bid_cmd,
    output ob_msg_pkg::store_cmd_e  o_ask_cmd,
    output logic [SW-1:0]           o_stock,
    output ob_cfg_pkg::qty_t        o_qty,
    output ob_cfg_pkg::price_t      o_price,
    output ob_cfg_pkg::order_id_t   o_id,
    input  logic                    i_bid_done,
    input  logic                    i_ask_done,
    input  logic                    i_bid_found,
    input  logic                    i_ask_found,
    output logic                    o_scan_start,
    input  logic                    i_bid_scan_done,
    input  logic                    i_ask_scan_done,
    input  ob_cfg_pkg::price_t      i_bid_best,
    input  ob_cfg_pkg::price_t      i_ask_best,
    output logic                    o_book_is_busy,
    output logic                    o_data_valid,
    output ob_cfg_pkg::price_t      o_best_bid,
    output ob_cfg_pkg::price_t      o_best_ask
);

    ob_msg_pkg::ctrl_state_e state;
    ob_msg_pkg::store_cmd_e  bid_cmd;
    ob_msg_pkg::store_cmd_e  ask_cmd;

    logic          bid_pend;
    logic          ask_pend;
    logic          bid_done;
    logic          ask_done;
    logic          any_found;
    logic          found_n;
    logic [SW-1:0] last_stock;

    // route the order kind to the store requests
    always_comb begin
        bid_cmd = ob_msg_pkg::NONE;
        ask_cmd = ob_msg_pkg::NONE;
        case (i_order_type)
            ob_msg_pkg::ADD: begin
                if (i_trade_type == ob_msg_pkg::SIDE_ASK) begin
                    ask_cmd = ob_msg_pkg::APPEND;
                end else begin
                    bid_cmd = ob_msg_pkg::APPEND;
                end
            end
            ob_msg_pkg::CANCEL: begin
                bid_cmd = ob_msg_pkg::REMOVE;
                ask_cmd = ob_msg_pkg::REMOVE;
            end
            ob_msg_pkg::EXECUTE: begin
                bid_cmd = ob_msg_pkg::REDUCE;
                ask_cmd = ob_msg_pkg::REDUCE;
            end
            default: ;
        endcase
    end

    // same pending flags serve the store phase and the scan phase
    assign bid_done = (state == ob_msg_pkg::SCAN) ? i_bid_scan_done : i_bid_done;
    assign ask_done = (state == ob_msg_pkg::SCAN) ? i_ask_scan_done : i_ask_done;
    assign found_n  = any_found | (i_bid_done & i_bid_found) | (i_ask_done & i_ask_found);

    always_ff @(posedge i_clk) begin
        if (i_data_valid && state == ob_msg_pkg::IDLE) begin
            o_stock <= i_stock_id;
            o_qty   <= i_quantity;
            o_price <= i_price;
            o_id    <= i_order_id;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state          <= ob_msg_pkg::IDLE;
            o_bid_cmd      <= ob_msg_pkg::NONE;
            o_ask_cmd      <= ob_msg_pkg::NONE;
            bid_pend       <= 1'b0;
            ask_pend       <= 1'b0;
            any_found      <= 1'b0;
            last_stock     <= '0;
            o_scan_start   <= 1'b0;
            o_book_is_busy <= 1'b0;
            o_data_valid   <= 1'b0;
            o_best_bid     <= '0;
            o_best_ask     <= '0;
        end else begin
            o_bid_cmd    <= ob_msg_pkg::NONE;
            o_ask_cmd    <= ob_msg_pkg::NONE;
            o_scan_start <= 1'b0;
            bid_pend     <= bid_pend & ~bid_done;
            ask_pend     <= ask_pend & ~ask_done;
            case (state)
                ob_msg_pkg::IDLE: begin
                    if (i_data_valid) begin
                        o_bid_cmd      <= bid_cmd;
                        o_ask_cmd      <= ask_cmd;
                        bid_pend       <= (bid_cmd != ob_msg_pkg::NONE);
                        ask_pend       <= (ask_cmd != ob_msg_pkg::NONE);
                        any_found      <= 1'b0;
                        o_book_is_busy <= 1'b1;
                        state          <= ob_msg_pkg::STORE_OP;
                    end
                end
                ob_msg_pkg::STORE_OP: begin
                    any_found <= found_n;
                    if (!(bid_pend & ~bid_done) && !(ask_pend & ~ask_done)) begin
                        if (found_n || o_stock != last_stock) begin
                            o_scan_start <= 1'b1;
                            bid_pend     <= 1'b1;
                            ask_pend     <= 1'b1;
                            state        <= ob_msg_pkg::SCAN;
                        end else begin
                            // book untouched, held bests are still current
                            o_data_valid   <= 1'b1;
                            o_book_is_busy <= 1'b0;
                            state          <= ob_msg_pkg::FINISH;
                        end
                    end
                end
                ob_msg_pkg::SCAN: begin
                    if (i_bid_scan_done) begin
                        o_best_bid <= i_bid_best;
                    end
                    if (i_ask_scan_done) begin
                        o_best_ask <= i_ask_best;
                    end
                    if (!(bid_pend & ~bid_done) && !(ask_pend & ~ask_done)) begin
                        last_stock     <= o_stock;
                        o_data_valid   <= 1'b1;
                        o_book_is_busy <= 1'b0;
                        state          <= ob_msg_pkg::FINISH;
                    end
                end
                ob_msg_pkg::FINISH: begin
                    // hold the result until the trading logic takes it
                    if (i_trading_logic_ready) begin
                        o_data_valid <= 1'b0;
                        state        <= ob_msg_pkg::IDLE;
                    end
                end
                default: state <= ob_msg_pkg::IDLE;
            endcase
        end
    end

endmodule

//--- design/order_book_top.sv
`timescale 1ns/1ns
// limit order book top level

module order_book_top #(
    parameter int NUM_STOCKS = 4,
    parameter int BOOK_DEPTH = 8,
    localparam int SW = $clog2(NUM_STOCKS)
) (
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_data_valid,
    input  logic                    i_trade_type,
    input  logic [SW-1:0]           i_stock_id,
    input  ob_msg_pkg::order_kind_e i_order_type,
    input  ob_cfg_pkg::qty_t        i_quantity,
    input  ob_cfg_pkg::price_t      i_price,
    input  ob_cfg_pkg::order_id_t   i_order_id,
    input  logic                    i_trading_logic_ready,
    output logic                    o_book_is_busy,
    output logic                    o_data_valid,
    output ob_cfg_pkg::price_t      o_best_bid,
    output ob_cfg_pkg::price_t      o_best_ask
);

    localparam int IW = $clog2(BOOK_DEPTH);

    ob_msg_pkg::store_cmd_e bid_cmd, ask_cmd;
    logic [SW-1:0]          stock, bid_rd_stock, ask_rd_stock;
    ob_cfg_pkg::qty_t       qty;
    ob_cfg_pkg::price_t     price, bid_best, ask_best, bid_rd_price, ask_rd_price;
    ob_cfg_pkg::order_id_t  id;
    logic                   bid_done, ask_done, bid_found, ask_found;
    logic                   scan_start, bid_scan_done, ask_scan_done;
    logic [IW-1:0]          bid_rd_idx, ask_rd_idx;
    logic                   bid_rd_valid, ask_rd_valid;

    book_ctrl #(.NUM_STOCKS(NUM_STOCKS)) ctrl0 (
        .i_clk, .i_reset_n, .i_data_valid, .i_trade_type, .i_stock_id, .i_order_type,
        .i_quantity, .i_price, .i_order_id, .i_trading_logic_ready,
        .o_bid_cmd(bid_cmd), .o_ask_cmd(ask_cmd), .o_stock(stock), .o_qty(qty),
        .o_price(price), .o_id(id), .i_bid_done(bid_done), .i_ask_done(ask_done),
        .i_bid_found(bid_found), .i_ask_found(ask_found), .o_scan_start(scan_start),
        .i_bid_scan_done(bid_scan_done), .i_ask_scan_done(ask_scan_done),
        .i_bid_best(bid_best), .i_ask_best(ask_best),
        .o_book_is_busy, .o_data_valid, .o_best_bid, .o_best_ask
    );

    book_store #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) bid_store0 (
        .i_clk, .i_reset_n, .i_cmd(bid_cmd), .i_stock(stock), .i_qty(qty),
        .i_price(price), .i_id(id), .o_done(bid_done), .o_found(bid_found),
        .i_rd_stock(bid_rd_stock), .i_rd_idx(bid_rd_idx),
        .o_rd_price(bid_rd_price), .o_rd_valid(bid_rd_valid)
    );

    book_store #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) ask_store0 (
        .i_clk, .i_reset_n, .i_cmd(ask_cmd), .i_stock(stock), .i_qty(qty),
        .i_price(price), .i_id(id), .o_done(ask_done), .o_found(ask_found),
        .i_rd_stock(ask_rd_stock), .i_rd_idx(ask_rd_idx),
        .o_rd_price(ask_rd_price), .o_rd_valid(ask_rd_valid)
    );

    best_price_scan #(
        .NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH), .FIND_MAX(1'b1)
    ) bid_scan0 (
        .i_clk, .i_reset_n, .i_start(scan_start), .i_stock(stock),
        .o_rd_stock(bid_rd_stock), .o_rd_idx(bid_rd_idx), .i_rd_price(bid_rd_price),
        .i_rd_valid(bid_rd_valid), .o_done(bid_scan_done), .o_best(bid_best)
    );

    best_price_scan #(
        .NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH), .FIND_MAX(1'b0)
    ) ask_scan0 (
        .i_clk, .i_reset_n, .i_start(scan_start), .i_stock(stock),
        .o_rd_stock(ask_rd_stock), .o_rd_idx(ask_rd_idx), .i_rd_price(ask_rd_price),
        .i_rd_valid(ask_rd_valid), .o_done(ask_scan_done), .o_best(ask_best)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns
// testbench clock source

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

//--- sim/order_book_checker.sv
`timescale 1ns/1ns
// order book handshake assertions

module order_book_checker (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_ready,
    input logic i_valid,
    input logic i_busy
);

    // a result is only shown once the book has finished
    valid_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_valid |-> !i_busy)
        else $error("o_data_valid high while o_book_is_busy is high");

    // result held until the trading logic is ready
    valid_held: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_valid && !i_ready) |=> i_valid)
        else $error("o_data_valid dropped while i_trading_logic_ready was low");

    reset_quiet: assert property (@(posedge i_clk)
        !i_reset_n |=> (!i_valid && !i_busy))
        else $error("handshake output high during reset");

endmodule

bind order_book_top order_book_checker checker0 (
    .i_clk(i_clk),
    .i_reset_n(i_reset_n),
    .i_ready(i_trading_logic_ready),
    .i_valid(o_data_valid),
    .i_busy(o_book_is_busy)
);

//--- sim/order_book_tb.sv
`timescale 1ns/1ns
// limit order book testbench

module order_book_tb;

    localparam int NUM_STOCKS = 4;
    localparam int BOOK_DEPTH = 8;
    localparam int SW         = $clog2(NUM_STOCKS);
    localparam int TIMEOUT    = 200;

    logic                    clk;
    logic                    reset_n;
    logic                    data_valid;
    logic                    trade_type;
    logic [SW-1:0]           stock_id;
    ob_msg_pkg::order_kind_e order_type;
    ob_cfg_pkg::qty_t        quantity;
    ob_cfg_pkg::price_t      price;
    ob_cfg_pkg::order_id_t   order_id;
    logic                    ready;
    logic                    busy;
    logic                    out_valid;
    ob_cfg_pkg::price_t      best_bid;
    ob_cfg_pkg::price_t      best_ask;

    // reference book by side, stock and slot
    ob_cfg_pkg::qty_t      m_qty   [2][NUM_STOCKS][BOOK_DEPTH];
    ob_cfg_pkg::price_t    m_price [2][NUM_STOCKS][BOOK_DEPTH];
    ob_cfg_pkg::order_id_t m_id    [2][NUM_STOCKS][BOOK_DEPTH];
    int                    m_count [2][NUM_STOCKS];

    ob_cfg_pkg::price_t exp_bid;
    ob_cfg_pkg::price_t exp_ask;
    logic               exp_pending;
    logic               valid_prev;
    string              test_name;
    int                 tests;
    int                 errors;
    int                 seed;

    tb_clock_gen #(.PERIOD_NS(20)) clk_gen0 (.o_clk(clk));

    order_book_top #(.NUM_STOCKS(NUM_STOCKS), .BOOK_DEPTH(BOOK_DEPTH)) dut0 (
        .i_clk(clk), .i_reset_n(reset_n), .i_data_valid(data_valid),
        .i_trade_type(trade_type), .i_stock_id(stock_id), .i_order_type(order_type),
        .i_quantity(quantity), .i_price(price), .i_order_id(order_id),
        .i_trading_logic_ready(ready), .o_book_is_busy(busy), .o_data_valid(out_valid),
        .o_best_bid(best_bid), .o_best_ask(best_ask)
    );

    // highest bid or lowest ask, 0 for an empty side
    function automatic ob_cfg_pkg::price_t best_price(input int side, input int stock);
        ob_cfg_pkg::price_t best;
        best = '0;
        for (int k = 0; k < m_count[side][stock]; k++) begin
            if (k == 0 || (side == 0 && m_price[side][stock][k] > best) ||
                (side == 1 && m_price[side][stock][k] < best)) begin
                best = m_price[side][stock][k];
            end
        end
        return best;
    endfunction

    task automatic apply_order(input ob_msg_pkg::order_kind_e kind, input int side,
                               input int stock, input ob_cfg_pkg::qty_t qty,
                               input ob_cfg_pkg::price_t prc, input ob_cfg_pkg::order_id_t id);
        int pos;
        int n;
        if (kind == ob_msg_pkg::ADD) begin
            n = m_count[side][stock];
            // a full side drops the add
            if (n < BOOK_DEPTH) begin
                m_qty[side][stock][n]   = qty;
                m_price[side][stock][n] = prc;
                m_id[side][stock][n]    = id;
                m_count[side][stock]    = n + 1;
            end
        end else begin
            for (int s = 0; s < 2; s++) begin
                pos = -1;
                for (int k = 0; k < m_count[s][stock]; k++) begin
                    if (pos < 0 && m_id[s][stock][k] == id) begin
                        pos = k;
                    end
                end
                if (pos >= 0 && kind == ob_msg_pkg::EXECUTE && qty < m_qty[s][stock][pos]) begin
                    m_qty[s][stock][pos] = m_qty[s][stock][pos] - qty;
                end else if (pos >= 0) begin
                    // compact the later entries down
                    for (int k = pos; k < m_count[s][stock] - 1; k++) begin
                        m_qty[s][stock][k]   = m_qty[s][stock][k + 1];
                        m_price[s][stock][k] = m_price[s][stock][k + 1];
                        m_id[s][stock][k]    = m_id[s][stock][k + 1];
                    end
                    m_count[s][stock] = m_count[s][stock] - 1;
                end
            end
        end
    endtask

    // resting id of that stock, now and then one that is not in the book
    function automatic ob_cfg_pkg::order_id_t pick_id(input int side, input int stock, input int r);
        int s;
        s = (m_count[side][stock] > 0) ? side : 1 - side;
        if (m_count[s][stock] == 0 || r % 8 == 0) begin
            return 32'h8000_0000 + r;
        end
        return m_id[s][stock][r % m_count[s][stock]];
    endfunction

    task automatic finish_run();
        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout waiting for %s during %s", what, test_name);
        errors++;
        finish_run();
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((busy || out_valid) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy || out_valid) begin
            timeout_fail("the book to go idle");
        end
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        while (!busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!busy) begin
            timeout_fail("the order to be accepted");
        end else begin
            data_valid = 1'b0;
        end
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (exp_pending && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_pending) begin
            timeout_fail("o_data_valid");
        end
    endtask

    // updates the reference book and drives the order fields
    task automatic present_order(input string name, input ob_msg_pkg::order_kind_e kind,
                                 input logic side, input int stock, input ob_cfg_pkg::qty_t qty,
                                 input ob_cfg_pkg::price_t prc, input ob_cfg_pkg::order_id_t id);
        apply_order(kind, side, stock, qty, prc, id);
        exp_bid     = best_price(0, stock);
        exp_ask     = best_price(1, stock);
        test_name   = name;
        exp_pending = 1'b1;
        trade_type  = side;
        stock_id    = SW'(stock);
        order_type  = kind;
        quantity    = qty;
        price       = prc;
        order_id    = id;
        data_valid  = 1'b1;
    endtask

    task automatic send_order(input string name, input ob_msg_pkg::order_kind_e kind,
                              input logic side, input int stock, input ob_cfg_pkg::qty_t qty,
                              input ob_cfg_pkg::price_t prc, input ob_cfg_pkg::order_id_t id);
        wait_idle();
        present_order(name, kind, side, stock, qty, prc, id);
        wait_accept();
        wait_result();
    endtask

    // compare on the rising edge of o_data_valid
    always @(negedge clk) begin
        if (out_valid && !valid_prev && exp_pending) begin
            tests++;
            if (best_bid !== exp_bid || best_ask !== exp_ask) begin
                $display("Fail %s expected bid %0d ask %0d actual bid %0d ask %0d",
                         test_name, exp_bid, exp_ask, best_bid, best_ask);
                errors++;
            end else begin
                $display("ok   %s bid %0d ask %0d", test_name, best_bid, best_ask);
            end
            exp_pending = 1'b0;
        end
        valid_prev = out_valid;
    end

    initial begin
        int   stk;
        int   sd;
        int   pick;
        int   r;
        int   next_id;
        logic stalled_ok;
        reset_n     = 1'b0;
        data_valid  = 1'b0;
        trade_type  = 1'b0;
        stock_id    = '0;
        order_type  = ob_msg_pkg::ADD;
        quantity    = '0;
        price       = '0;
        order_id    = '0;
        ready       = 1'b1;
        exp_pending = 1'b0;
        valid_prev  = 1'b0;
        test_name   = "reset";
        tests       = 0;
        errors      = 0;
        seed        = 99882;
        next_id     = 1000;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < NUM_STOCKS; k++) begin
                m_count[s][k] = 0;
            end
        end
        repeat (5) @(negedge clk);
        reset_n = 1'b1;

        // two stocks, best of each side
        send_order("add_bid_s0_a", ob_msg_pkg::ADD, 1'b0, 0, 50, 100, 1);
        send_order("add_bid_s0_b", ob_msg_pkg::ADD, 1'b0, 0, 20, 105, 2);
        send_order("add_bid_s0_c", ob_msg_pkg::ADD, 1'b0, 0, 10, 98, 3);
        send_order("add_ask_s0_a", ob_msg_pkg::ADD, 1'b1, 0, 30, 110, 4);
        send_order("add_ask_s0_b", ob_msg_pkg::ADD, 1'b1, 0, 30, 108, 5);
        send_order("add_bid_s1", ob_msg_pkg::ADD, 1'b0, 1, 25, 50, 6);
        send_order("add_ask_s1", ob_msg_pkg::ADD, 1'b1, 1, 25, 60, 7);

        send_order("cancel_best_bid", ob_msg_pkg::CANCEL, 1'b0, 0, 0, 0, 2);
        send_order("cancel_unknown", ob_msg_pkg::CANCEL, 1'b0, 0, 0, 0, 77);

        send_order("exec_partial", ob_msg_pkg::EXECUTE, 1'b1, 0, 10, 0, 5);
        send_order("exec_full", ob_msg_pkg::EXECUTE, 1'b1, 0, 20, 0, 5);

        // trading logic stalls with a second order waiting
        ready = 1'b0;
        send_order("stall_first", ob_msg_pkg::ADD, 1'b1, 0, 40, 102, 30);
        present_order("stall_second", ob_msg_pkg::ADD, 1'b0, 0, 15, 104, 31);
        stalled_ok = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (!out_valid || busy) begin
                stalled_ok = 1'b0;
            end
        end
        tests++;
        if (stalled_ok) begin
            $display("ok   stall_hold result held and no order taken");
        end else begin
            $display("stall_hold: result dropped or an order was taken while not ready");
            errors++;
        end
        ready = 1'b1;
        wait_accept();
        wait_result();

        // fill one side, the extra better price must not show
        for (int k = 0; k < BOOK_DEPTH; k++) begin
            send_order($sformatf("fill_%0d", k), ob_msg_pkg::ADD, 1'b0, 2, 10, 200 + k, 40 + k);
        end
        send_order("full_extra", ob_msg_pkg::ADD, 1'b0, 2, 10, 900, 48);

        for (int i = 0; i < 200; i++) begin
            stk  = $unsigned($random(seed)) % NUM_STOCKS;
            sd   = $unsigned($random(seed)) % 2;
            pick = $unsigned($random(seed)) % 10;
            r    = $unsigned($random(seed)) % 4096;
            if (pick < 5) begin
                send_order($sformatf("rand_%0d_add", i), ob_msg_pkg::ADD, sd[0], stk,
                           1 + r % 200, 1 + r % 999, next_id);
                next_id++;
            end else if (pick < 8) begin
                send_order($sformatf("rand_%0d_cancel", i), ob_msg_pkg::CANCEL, sd[0], stk,
                           0, 0, pick_id(sd, stk, r));
            end else begin
                send_order($sformatf("rand_%0d_exec", i), ob_msg_pkg::EXECUTE, sd[0], stk,
                           1 + r % 300, 0, pick_id(sd, stk, r));
            end
        end

        wait_idle();
        finish_run();
    end

endmodule

//--- files.f
design/ob_cfg_pkg.sv
design/ob_msg_pkg.sv
design/book_store.sv
design/best_price_scan.sv
design/book_ctrl.sv
design/order_book_top.sv
sim/tb_clock_gen.sv
sim/order_book_checker.sv
sim/order_book_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line
verilator --binary --timing --assert -Wno-fatal --top-module order_book_tb \
    -f files.f -o order_book_sim \
    && { out=$(./obj_dir/order_book_sim 2>&1); printf '%s\n' "$out"; } \
    && printf '%s\n' "$out" | grep -qx "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
